//--- Makefile
TOP := tb_pipeline_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module pipeline_ctrl riscv_pkg.sv operand_bypass.sv pipe_sequencer.sv pipeline_ctrl.sv

sim:
	verilator --binary --timing -f project.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

//--- operand_bypass.sv
// operand forwarding into EX and load-use detection for the split memory stages
// purely combinational, sits beside the ID/EX register
`timescale 1ns/1ps

module operand_bypass
    import riscv_pkg::*;
(
    // sources of the instruction in ID/EX
    input  reg_addr_t id_ex_rs1_addr_i,
    input  reg_addr_t id_ex_rs2_addr_i,
    // register file read values
    input  word_t     id_ex_rs1_data_i,
    input  word_t     id_ex_rs2_data_i,

    // destinations of the older instructions
    input  reg_addr_t ex_mem1_rd_addr_i,
    input  reg_addr_t mem1_mem2_rd_addr_i,
    input  reg_addr_t mem2_wb_rd_addr_i,
    input  logic      ex_mem1_write_rd_i,
    input  logic      mem1_mem2_write_rd_i,
    input  logic      mem2_wb_write_rd_i,
    input  mem_oper_t ex_mem1_mem_oper_i,
    input  mem_oper_t mem1_mem2_mem_oper_i,
    input  mem_oper_t mem2_wb_mem_oper_i,

    // candidate forwarding data
    input  word_t     ex_mem1_alu_result_i,
    input  word_t     mem1_mem2_alu_result_i,
    input  word_t     mem2_wb_alu_result_i,
    input  word_t     mem2_wb_lsu_rdata_i,

    // finished operands for EX
    output word_t     ex_rs1_data_o,
    output word_t     ex_rs2_data_o,
    output logic      load_use_o
);

    logic  ex_mem1_fwd_ok;
    logic  mem1_mem2_fwd_ok;
    logic  mem2_wb_fwd_ok;
    word_t mem2_wb_fwd_data;
    logic  ex_mem1_load;
    logic  mem1_mem2_load;
    logic  ex_mem1_load_rs1;
    logic  ex_mem1_load_rs2;
    logic  mem1_mem2_load_rs1;
    logic  mem1_mem2_load_rs2;

    // a load in EX/MEM1 only has its address, not the data
    assign ex_mem1_fwd_ok = ex_mem1_write_rd_i && (ex_mem1_rd_addr_i != '0)
        && !is_mem_oper_load(ex_mem1_mem_oper_i);
    // load data is still in flight while in MEM1/MEM2
    assign mem1_mem2_fwd_ok = mem1_mem2_write_rd_i && (mem1_mem2_rd_addr_i != '0)
        && !is_mem_oper_load(mem1_mem2_mem_oper_i);
    assign mem2_wb_fwd_ok = mem2_wb_write_rd_i && (mem2_wb_rd_addr_i != '0);

    // by WB the lsu has returned the loaded value
    assign mem2_wb_fwd_data = is_mem_oper_load(mem2_wb_mem_oper_i) ?
        mem2_wb_lsu_rdata_i : mem2_wb_alu_result_i;

    // youngest matching stage wins, register file otherwise
    function automatic word_t select_operand(input reg_addr_t rs, input word_t rf_data);
        word_t operand;
        if (ex_mem1_fwd_ok && (ex_mem1_rd_addr_i == rs))
            operand = ex_mem1_alu_result_i;
        else if (mem1_mem2_fwd_ok && (mem1_mem2_rd_addr_i == rs))
            operand = mem1_mem2_alu_result_i;
        else if (mem2_wb_fwd_ok && (mem2_wb_rd_addr_i == rs))
            operand = mem2_wb_fwd_data;
        else
            operand = rf_data;
        return operand;
    endfunction

    always_comb
    begin
        ex_rs1_data_o = select_operand(id_ex_rs1_addr_i, id_ex_rs1_data_i);
    end

    always_comb
    begin
        ex_rs2_data_o = select_operand(id_ex_rs2_addr_i, id_ex_rs2_data_i);
    end

    // loads that produce a real register value
    assign ex_mem1_load   = is_mem_oper_load(ex_mem1_mem_oper_i) && (ex_mem1_rd_addr_i != '0);
    assign mem1_mem2_load = is_mem_oper_load(mem1_mem2_mem_oper_i)
        && (mem1_mem2_rd_addr_i != '0);

    // consumer right behind the load waits two cycles
    assign ex_mem1_load_rs1 = ex_mem1_load && (ex_mem1_rd_addr_i == id_ex_rs1_addr_i);
    assign ex_mem1_load_rs2 = ex_mem1_load && (ex_mem1_rd_addr_i == id_ex_rs2_addr_i);

    // one cycle further the load still blocks,
    // unless a newer alu result in EX/MEM1 overrides it for that register
    assign mem1_mem2_load_rs1 = mem1_mem2_load && (mem1_mem2_rd_addr_i == id_ex_rs1_addr_i)
        && !(ex_mem1_fwd_ok && (ex_mem1_rd_addr_i == id_ex_rs1_addr_i));
    assign mem1_mem2_load_rs2 = mem1_mem2_load && (mem1_mem2_rd_addr_i == id_ex_rs2_addr_i)
        && !(ex_mem1_fwd_ok && (ex_mem1_rd_addr_i == id_ex_rs2_addr_i));

    assign load_use_o = ex_mem1_load_rs1 || ex_mem1_load_rs2
        || mem1_mem2_load_rs1 || mem1_mem2_load_rs2;

endmodule

//--- pipe_sequencer.sv
// trap and interrupt sequencing, fetch steering and pipeline stall/flush control
// outputs are combinational from the inputs and the RUN/TRAP_WAIT state
`timescale 1ns/1ps

module pipe_sequencer
    import riscv_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,

    // from the bypass unit
    input  logic      load_use_i,

    // csr instructions in flight serialize the pipeline
    input  logic      id_is_csr_i,
    input  logic      ex_is_csr_i,
    input  logic      mem1_is_csr_i,
    input  logic      mem2_is_csr_i,

    // memory back-pressure
    input  logic      lsu_req_stall_i,
    input  logic      mem2_stall_needed_i,

    // taken branch or jump resolved in EX
    input  logic      ex_new_pc_en_i,

    // trap and interrupt sources
    input  logic      mstatus_mie_i,
    input  exc_t      mem_trap_i,
    input  priv_lvl_e current_plvl_i,
    input  irqs_t     irq_pending_i,

    // fetch redirect
    output logic      new_pc_en_o,
    output pc_sel_t   pc_sel_o,

    // to the csr file
    output logic      csr_mret_o,
    output logic      is_trap_o,
    output mcause_t   csr_mcause_o,

    // pipeline register controls
    output logic      if_id_stall_o,
    output logic      if_id_flush_o,
    output logic      id_ex_stall_o,
    output logic      id_ex_flush_o,
    output logic      ex_mem1_stall_o,
    output logic      ex_mem1_flush_o,
    output logic      mem1_mem2_stall_o,
    output logic      mem1_mem2_flush_o,
    output logic      mem2_wb_stall_o,
    output logic      mem2_wb_flush_o
);

    typedef enum logic
    {
        RUN,
        TRAP_WAIT
    } seq_state_t;

    seq_state_t state_q;
    seq_state_t state_d;
    logic       irq_en;
    logic       take_irq;
    logic [3:0] irq_code;

    // mie does not gate interrupts while running in user mode
    assign irq_en   = mstatus_mie_i || (current_plvl_i == PRIV_LVL_U);
    assign take_irq = irq_en && (|irq_pending_i);

    // software first, then timer, then external
    always_comb
    begin
        if (irq_pending_i[IRQ_M_SOFTWARE])
            irq_code = CSR_MSI_BIT;
        else if (irq_pending_i[IRQ_M_TIMER])
            irq_code = CSR_MTI_BIT;
        else if (irq_pending_i[IRQ_M_EXTERNAL])
            irq_code = CSR_MEI_BIT;
        else
            irq_code = '0;
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            state_q <= RUN;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d      = state_q;
        new_pc_en_o  = 1'b0;
        pc_sel_o     = PC_JUMP;
        csr_mret_o   = 1'b0;
        is_trap_o    = 1'b0;
        // exception cause by default, the interrupt path overrides it
        csr_mcause_o = {1'b0, mem_trap_i[3:0]};

        // hazard and serialization controls, active in every state
        if_id_stall_o     = load_use_i || ex_is_csr_i || mem1_is_csr_i || mem2_is_csr_i;
        if_id_flush_o     = id_is_csr_i || ex_is_csr_i || mem1_is_csr_i || mem2_is_csr_i;
        id_ex_stall_o     = load_use_i;
        id_ex_flush_o     = 1'b0;
        // bubble behind the instruction held in ID/EX
        ex_mem1_stall_o   = lsu_req_stall_i;
        ex_mem1_flush_o   = load_use_i;
        mem1_mem2_stall_o = mem2_stall_needed_i;
        mem1_mem2_flush_o = lsu_req_stall_i;
        mem2_wb_stall_o   = 1'b0;
        mem2_wb_flush_o   = mem2_stall_needed_i;

        case (state_q)
            RUN:
            begin
                if (mem_trap_i != NO_TRAP)
                begin
                    // MEM2 commits the trap, younger work is squashed
                    id_ex_flush_o   = 1'b1;
                    ex_mem1_flush_o = 1'b1;
                    new_pc_en_o     = 1'b1;
                    state_d         = TRAP_WAIT;
                    if (mem_trap_i == MRET)
                    begin
                        pc_sel_o   = PC_MEPC;
                        csr_mret_o = 1'b1;
                    end
                    else
                    begin
                        pc_sel_o  = PC_TRAP;
                        is_trap_o = 1'b1;
                    end
                end
                else if (take_irq)
                begin
                    id_ex_flush_o   = 1'b1;
                    ex_mem1_flush_o = 1'b1;
                    new_pc_en_o     = 1'b1;
                    pc_sel_o        = PC_TRAP;
                    is_trap_o       = 1'b1;
                    csr_mcause_o    = {1'b1, irq_code};
                    state_d         = TRAP_WAIT;
                end
                else if (ex_new_pc_en_i)
                begin
                    // not-taken prediction missed, drop the wrong-path instruction
                    new_pc_en_o   = 1'b1;
                    id_ex_flush_o = 1'b1;
                end
            end
            TRAP_WAIT:
            begin
                // csr file clears mie during this cycle
                state_d = RUN;
            end
            default:
            begin
                state_d = RUN;
            end
        endcase
    end

endmodule

//--- pipeline_ctrl.sv
// pipeline control top, joins operand forwarding with trap and hazard sequencing
// connects straight to the datapath pipeline registers, fetch unit and csr file
`timescale 1ns/1ps

module pipeline_ctrl
    import riscv_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,

    // ID/EX operands
    input  reg_addr_t id_ex_rs1_addr_i,
    input  reg_addr_t id_ex_rs2_addr_i,
    input  word_t     id_ex_rs1_data_i,
    input  word_t     id_ex_rs2_data_i,

    // older stages
    input  reg_addr_t ex_mem1_rd_addr_i,
    input  reg_addr_t mem1_mem2_rd_addr_i,
    input  reg_addr_t mem2_wb_rd_addr_i,
    input  logic      ex_mem1_write_rd_i,
    input  logic      mem1_mem2_write_rd_i,
    input  logic      mem2_wb_write_rd_i,
    input  mem_oper_t ex_mem1_mem_oper_i,
    input  mem_oper_t mem1_mem2_mem_oper_i,
    input  mem_oper_t mem2_wb_mem_oper_i,
    input  word_t     ex_mem1_alu_result_i,
    input  word_t     mem1_mem2_alu_result_i,
    input  word_t     mem2_wb_alu_result_i,
    input  word_t     mem2_wb_lsu_rdata_i,

    // csr serialization, back-pressure, branch
    input  logic      id_is_csr_i,
    input  logic      ex_is_csr_i,
    input  logic      mem1_is_csr_i,
    input  logic      mem2_is_csr_i,
    input  logic      lsu_req_stall_i,
    input  logic      mem2_stall_needed_i,
    input  logic      ex_new_pc_en_i,

    // traps and interrupts
    input  logic      mstatus_mie_i,
    input  exc_t      mem_trap_i,
    input  priv_lvl_e current_plvl_i,
    input  irqs_t     irq_pending_i,

    // bypassed EX operands
    output word_t     ex_rs1_data_o,
    output word_t     ex_rs2_data_o,

    // fetch steering and csr file
    output logic      new_pc_en_o,
    output pc_sel_t   pc_sel_o,
    output logic      csr_mret_o,
    output logic      is_trap_o,
    output mcause_t   csr_mcause_o,

    // pipeline register controls
    output logic      if_id_stall_o,
    output logic      if_id_flush_o,
    output logic      id_ex_stall_o,
    output logic      id_ex_flush_o,
    output logic      ex_mem1_stall_o,
    output logic      ex_mem1_flush_o,
    output logic      mem1_mem2_stall_o,
    output logic      mem1_mem2_flush_o,
    output logic      mem2_wb_stall_o,
    output logic      mem2_wb_flush_o
);

    // load consumer must wait in ID/EX
    logic load_use;

    operand_bypass u_operand_bypass (
        .id_ex_rs1_addr_i      (id_ex_rs1_addr_i),
        .id_ex_rs2_addr_i      (id_ex_rs2_addr_i),
        .id_ex_rs1_data_i      (id_ex_rs1_data_i),
        .id_ex_rs2_data_i      (id_ex_rs2_data_i),
        .ex_mem1_rd_addr_i     (ex_mem1_rd_addr_i),
        .mem1_mem2_rd_addr_i   (mem1_mem2_rd_addr_i),
        .mem2_wb_rd_addr_i     (mem2_wb_rd_addr_i),
        .ex_mem1_write_rd_i    (ex_mem1_write_rd_i),
        .mem1_mem2_write_rd_i  (mem1_mem2_write_rd_i),
        .mem2_wb_write_rd_i    (mem2_wb_write_rd_i),
        .ex_mem1_mem_oper_i    (ex_mem1_mem_oper_i),
        .mem1_mem2_mem_oper_i  (mem1_mem2_mem_oper_i),
        .mem2_wb_mem_oper_i    (mem2_wb_mem_oper_i),
        .ex_mem1_alu_result_i  (ex_mem1_alu_result_i),
        .mem1_mem2_alu_result_i(mem1_mem2_alu_result_i),
        .mem2_wb_alu_result_i  (mem2_wb_alu_result_i),
        .mem2_wb_lsu_rdata_i   (mem2_wb_lsu_rdata_i),
        .ex_rs1_data_o         (ex_rs1_data_o),
        .ex_rs2_data_o         (ex_rs2_data_o),
        .load_use_o            (load_use)
    );

    pipe_sequencer u_pipe_sequencer (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .load_use_i         (load_use),
        .id_is_csr_i        (id_is_csr_i),
        .ex_is_csr_i        (ex_is_csr_i),
        .mem1_is_csr_i      (mem1_is_csr_i),
        .mem2_is_csr_i      (mem2_is_csr_i),
        .lsu_req_stall_i    (lsu_req_stall_i),
        .mem2_stall_needed_i(mem2_stall_needed_i),
        .ex_new_pc_en_i     (ex_new_pc_en_i),
        .mstatus_mie_i      (mstatus_mie_i),
        .mem_trap_i         (mem_trap_i),
        .current_plvl_i     (current_plvl_i),
        .irq_pending_i      (irq_pending_i),
        .new_pc_en_o        (new_pc_en_o),
        .pc_sel_o           (pc_sel_o),
        .csr_mret_o         (csr_mret_o),
        .is_trap_o          (is_trap_o),
        .csr_mcause_o       (csr_mcause_o),
        .if_id_stall_o      (if_id_stall_o),
        .if_id_flush_o      (if_id_flush_o),
        .id_ex_stall_o      (id_ex_stall_o),
        .id_ex_flush_o      (id_ex_flush_o),
        .ex_mem1_stall_o    (ex_mem1_stall_o),
        .ex_mem1_flush_o    (ex_mem1_flush_o),
        .mem1_mem2_stall_o  (mem1_mem2_stall_o),
        .mem1_mem2_flush_o  (mem1_mem2_flush_o),
        .mem2_wb_stall_o    (mem2_wb_stall_o),
        .mem2_wb_flush_o    (mem2_wb_flush_o)
    );

endmodule

//--- project.f
riscv_pkg.sv
operand_bypass.sv
pipe_sequencer.sv
pipeline_ctrl.sv
tb_pipeline_ctrl.sv

//--- riscv_pkg.sv
// shared widths, encodings and helpers for the RV32 pipeline control logic
// import with riscv_pkg::* in any module header that needs them
package riscv_pkg;

    // register index, x0 reads as zero and never forwards
    typedef logic [4:0] reg_addr_t;

    // data word for alu results, load data and operands
    typedef logic [31:0] word_t;

    // memory operation carried by each pipeline register
    typedef enum logic [3:0]
    {
        MEM_NONE = 4'd0,
        LB       = 4'd1,
        LH       = 4'd2,
        LW       = 4'd3,
        LBU      = 4'd4,
        LHU      = 4'd5,
        SB       = 4'd6,
        SH       = 4'd7,
        SW       = 4'd8
    } mem_oper_t;

    // trap reported by the instruction in MEM2
    // values below MRET are the mcause exception codes
    typedef enum logic [3:0]
    {
        INSTR_MISALIGNED = 4'd0,
        ILLEGAL_INSTR    = 4'd2,
        BREAKPOINT       = 4'd3,
        LOAD_MISALIGNED  = 4'd4,
        STORE_MISALIGNED = 4'd6,
        ECALL_U          = 4'd8,
        ECALL_M          = 4'd11,
        MRET             = 4'd14,
        NO_TRAP          = 4'd15
    } exc_t;

    // source of the next fetch address on a redirect
    typedef enum logic [1:0]
    {
        PC_JUMP = 2'd0,
        PC_TRAP = 2'd1,
        PC_MEPC = 2'd2
    } pc_sel_t;

    typedef enum logic [1:0]
    {
        PRIV_LVL_U = 2'd0,
        PRIV_LVL_M = 2'd3
    } priv_lvl_e;

    // pending interrupts, one bit per source
    typedef logic [2:0] irqs_t;
    localparam int unsigned IRQ_M_SOFTWARE = 0;
    localparam int unsigned IRQ_M_TIMER    = 1;
    localparam int unsigned IRQ_M_EXTERNAL = 2;

    // bit 4 flags an interrupt, bits 3..0 hold the cause code
    typedef logic [4:0] mcause_t;

    // interrupt cause codes
    localparam logic [3:0] CSR_MSI_BIT = 4'd3;
    localparam logic [3:0] CSR_MTI_BIT = 4'd7;
    localparam logic [3:0] CSR_MEI_BIT = 4'd11;

    // true for the five load encodings
    function automatic logic is_mem_oper_load(input mem_oper_t oper);
        return oper inside {LB, LH, LW, LBU, LHU};
    endfunction

endpackage

//--- tb_pipeline_ctrl.sv
// self-checking random testbench for the pipeline control top level
// a reference model predicts every output, a checker compares just before each rising edge
`timescale 1ns/1ps

module tb_pipeline_ctrl
    import riscv_pkg::*;
();

    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CYCLES  = 2;
    localparam int NUM_CYCLES   = 4000;
    // twice the full run length at 10 ns per cycle
    localparam int WATCHDOG_NS  = 2 * (RESET_CYCLES + IDLE_CYCLES + NUM_CYCLES + 1) * 10;

    logic      clk_i = 1'b0;
    logic      rstn_i;
    reg_addr_t id_ex_rs1_addr_i;
    reg_addr_t id_ex_rs2_addr_i;
    word_t     id_ex_rs1_data_i;
    word_t     id_ex_rs2_data_i;
    reg_addr_t ex_mem1_rd_addr_i;
    reg_addr_t mem1_mem2_rd_addr_i;
    reg_addr_t mem2_wb_rd_addr_i;
    logic      ex_mem1_write_rd_i;
    logic      mem1_mem2_write_rd_i;
    logic      mem2_wb_write_rd_i;
    mem_oper_t ex_mem1_mem_oper_i;
    mem_oper_t mem1_mem2_mem_oper_i;
    mem_oper_t mem2_wb_mem_oper_i;
    word_t     ex_mem1_alu_result_i;
    word_t     mem1_mem2_alu_result_i;
    word_t     mem2_wb_alu_result_i;
    word_t     mem2_wb_lsu_rdata_i;
    logic      id_is_csr_i;
    logic      ex_is_csr_i;
    logic      mem1_is_csr_i;
    logic      mem2_is_csr_i;
    logic      lsu_req_stall_i;
    logic      mem2_stall_needed_i;
    logic      ex_new_pc_en_i;
    logic      mstatus_mie_i;
    exc_t      mem_trap_i;
    priv_lvl_e current_plvl_i;
    irqs_t     irq_pending_i;
    word_t     ex_rs1_data_o;
    word_t     ex_rs2_data_o;
    logic      new_pc_en_o;
    pc_sel_t   pc_sel_o;
    logic      csr_mret_o;
    logic      is_trap_o;
    mcause_t   csr_mcause_o;
    logic      if_id_stall_o;
    logic      if_id_flush_o;
    logic      id_ex_stall_o;
    logic      id_ex_flush_o;
    logic      ex_mem1_stall_o;
    logic      ex_mem1_flush_o;
    logic      mem1_mem2_stall_o;
    logic      mem1_mem2_flush_o;
    logic      mem2_wb_stall_o;
    logic      mem2_wb_flush_o;

    logic [31:0] rng_state;
    exc_t        trap_list [8];
    // model copy of the sequencer state, 1 while in TRAP_WAIT
    logic        model_wait;

    pipeline_ctrl u_pipeline_ctrl (.*);

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act)
        begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
            abort_run("operand mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
            abort_run("control bit mismatch");
        end
    endtask

    task automatic check_pc_sel(input string name, input pc_sel_t exp, input pc_sel_t act);
        if (exp !== act)
        begin
            $display("FAIL t=%0t %s expected %s actual %0d", $time, name, exp.name(), act);
            abort_run("fetch select mismatch");
        end
    endtask

    task automatic check_mcause(input string name, input mcause_t exp, input mcause_t act);
        if (exp !== act)
        begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
            abort_run("trap cause mismatch");
        end
    endtask

    function automatic logic is_load(input mem_oper_t oper);
        return (oper == LB) || (oper == LH) || (oper == LW) || (oper == LBU) || (oper == LHU);
    endfunction

    // youngest valid producer first, loads excluded until their data exists
    function automatic word_t ref_operand(input reg_addr_t rs, input word_t rf_data);
        logic ex_ok;
        logic m1_ok;
        logic wb_ok;
        ex_ok = ex_mem1_write_rd_i && (ex_mem1_rd_addr_i != '0) && !is_load(ex_mem1_mem_oper_i);
        m1_ok = mem1_mem2_write_rd_i && (mem1_mem2_rd_addr_i != '0)
            && !is_load(mem1_mem2_mem_oper_i);
        wb_ok = mem2_wb_write_rd_i && (mem2_wb_rd_addr_i != '0);
        if (ex_ok && (ex_mem1_rd_addr_i == rs))
            return ex_mem1_alu_result_i;
        if (m1_ok && (mem1_mem2_rd_addr_i == rs))
            return mem1_mem2_alu_result_i;
        if (wb_ok && (mem2_wb_rd_addr_i == rs))
            return is_load(mem2_wb_mem_oper_i) ? mem2_wb_lsu_rdata_i : mem2_wb_alu_result_i;
        return rf_data;
    endfunction

    function automatic logic ref_load_use();
        logic ex_fwd;
        logic ex_ld;
        logic m1_ld;
        logic hit;
        ex_fwd = ex_mem1_write_rd_i && (ex_mem1_rd_addr_i != '0) && !is_load(ex_mem1_mem_oper_i);
        ex_ld  = is_load(ex_mem1_mem_oper_i) && (ex_mem1_rd_addr_i != '0);
        m1_ld  = is_load(mem1_mem2_mem_oper_i) && (mem1_mem2_rd_addr_i != '0);
        hit = ex_ld && ((ex_mem1_rd_addr_i == id_ex_rs1_addr_i)
            || (ex_mem1_rd_addr_i == id_ex_rs2_addr_i));
        // a nearer alu result hides the older load for that register
        if (m1_ld && (mem1_mem2_rd_addr_i == id_ex_rs1_addr_i)
            && !(ex_fwd && (ex_mem1_rd_addr_i == id_ex_rs1_addr_i)))
            hit = 1'b1;
        if (m1_ld && (mem1_mem2_rd_addr_i == id_ex_rs2_addr_i)
            && !(ex_fwd && (ex_mem1_rd_addr_i == id_ex_rs2_addr_i)))
            hit = 1'b1;
        return hit;
    endfunction

    // trap over interrupt over branch, nothing while in TRAP_WAIT
    task automatic ref_redirect(output logic new_pc, output pc_sel_t sel, output logic mret,
                                output logic trap, output mcause_t cause,
                                output logic squash, output logic br_flush);
        logic irq_on;
        new_pc   = 1'b0;
        sel      = PC_JUMP;
        mret     = 1'b0;
        trap     = 1'b0;
        cause    = '0;
        squash   = 1'b0;
        br_flush = 1'b0;
        irq_on = (mstatus_mie_i || (current_plvl_i == PRIV_LVL_U)) && (irq_pending_i != '0);
        if (!model_wait)
        begin
            if (mem_trap_i != NO_TRAP)
            begin
                new_pc = 1'b1;
                squash = 1'b1;
                if (mem_trap_i == MRET)
                begin
                    sel  = PC_MEPC;
                    mret = 1'b1;
                end
                else
                begin
                    sel   = PC_TRAP;
                    trap  = 1'b1;
                    cause = mcause_t'(mem_trap_i);
                end
            end
            else if (irq_on)
            begin
                new_pc = 1'b1;
                squash = 1'b1;
                sel    = PC_TRAP;
                trap   = 1'b1;
                if (irq_pending_i[0])
                    cause = {1'b1, 4'd3};
                else if (irq_pending_i[1])
                    cause = {1'b1, 4'd7};
                else
                    cause = {1'b1, 4'd11};
            end
            else if (ex_new_pc_en_i)
            begin
                new_pc   = 1'b1;
                br_flush = 1'b1;
            end
        end
    endtask

    // stall/flush pairs, ordered from if_id down to mem2_wb
    function automatic logic [9:0] ref_ctrl(input logic lu, input logic squash,
                                            input logic br_flush);
        logic csr_late;
        csr_late = ex_is_csr_i || mem1_is_csr_i || mem2_is_csr_i;
        return {lu || csr_late, id_is_csr_i || csr_late, lu, squash || br_flush,
                lsu_req_stall_i, lu || squash, mem2_stall_needed_i, lsu_req_stall_i,
                1'b0, mem2_stall_needed_i};
    endfunction

    task automatic compare_outputs();
        logic       lu;
        logic       new_pc;
        pc_sel_t    sel;
        logic       mret;
        logic       trap;
        mcause_t    cause;
        logic       squash;
        logic       br_flush;
        logic [9:0] ctrl;
        lu = ref_load_use();
        ref_redirect(new_pc, sel, mret, trap, cause, squash, br_flush);
        ctrl = ref_ctrl(lu, squash, br_flush);
        check_word("ex_rs1_data_o", ref_operand(id_ex_rs1_addr_i, id_ex_rs1_data_i),
                   ex_rs1_data_o);
        check_word("ex_rs2_data_o", ref_operand(id_ex_rs2_addr_i, id_ex_rs2_data_i),
                   ex_rs2_data_o);
        check_bit("new_pc_en_o", new_pc, new_pc_en_o);
        check_pc_sel("pc_sel_o", sel, pc_sel_o);
        check_bit("csr_mret_o", mret, csr_mret_o);
        check_bit("is_trap_o", trap, is_trap_o);
        // mcause only has a meaning while a trap is taken
        if (trap)
            check_mcause("csr_mcause_o", cause, csr_mcause_o);
        check_bit("if_id_stall_o", ctrl[9], if_id_stall_o);
        check_bit("if_id_flush_o", ctrl[8], if_id_flush_o);
        check_bit("id_ex_stall_o", ctrl[7], id_ex_stall_o);
        check_bit("id_ex_flush_o", ctrl[6], id_ex_flush_o);
        check_bit("ex_mem1_stall_o", ctrl[5], ex_mem1_stall_o);
        check_bit("ex_mem1_flush_o", ctrl[4], ex_mem1_flush_o);
        check_bit("mem1_mem2_stall_o", ctrl[3], mem1_mem2_stall_o);
        check_bit("mem1_mem2_flush_o", ctrl[2], mem1_mem2_flush_o);
        check_bit("mem2_wb_stall_o", ctrl[1], mem2_wb_stall_o);
        check_bit("mem2_wb_flush_o", ctrl[0], mem2_wb_flush_o);
        // a taken trap or interrupt holds the sequencer for one cycle
        model_wait = rstn_i ? (!model_wait && squash) : 1'b0;
    endtask

    task automatic set_idle();
        id_ex_rs1_addr_i       = '0;
        id_ex_rs2_addr_i       = '0;
        id_ex_rs1_data_i       = '0;
        id_ex_rs2_data_i       = '0;
        ex_mem1_rd_addr_i      = '0;
        mem1_mem2_rd_addr_i    = '0;
        mem2_wb_rd_addr_i      = '0;
        ex_mem1_write_rd_i     = 1'b0;
        mem1_mem2_write_rd_i   = 1'b0;
        mem2_wb_write_rd_i     = 1'b0;
        ex_mem1_mem_oper_i     = MEM_NONE;
        mem1_mem2_mem_oper_i   = MEM_NONE;
        mem2_wb_mem_oper_i     = MEM_NONE;
        ex_mem1_alu_result_i   = '0;
        mem1_mem2_alu_result_i = '0;
        mem2_wb_alu_result_i   = '0;
        mem2_wb_lsu_rdata_i    = '0;
        id_is_csr_i            = 1'b0;
        ex_is_csr_i            = 1'b0;
        mem1_is_csr_i          = 1'b0;
        mem2_is_csr_i          = 1'b0;
        lsu_req_stall_i        = 1'b0;
        mem2_stall_needed_i    = 1'b0;
        ex_new_pc_en_i         = 1'b0;
        mstatus_mie_i          = 1'b0;
        mem_trap_i             = NO_TRAP;
        current_plvl_i         = PRIV_LVL_M;
        irq_pending_i          = '0;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        // addresses from x0..x3 so matches and x0 come up often
        r = xorshift32();
        id_ex_rs1_addr_i     = reg_addr_t'(r[1:0]);
        id_ex_rs2_addr_i     = reg_addr_t'(r[3:2]);
        ex_mem1_rd_addr_i    = reg_addr_t'(r[5:4]);
        mem1_mem2_rd_addr_i  = reg_addr_t'(r[7:6]);
        mem2_wb_rd_addr_i    = reg_addr_t'(r[9:8]);
        ex_mem1_write_rd_i   = r[10];
        mem1_mem2_write_rd_i = r[11];
        mem2_wb_write_rd_i   = r[12];
        ex_mem1_mem_oper_i   = mem_oper_t'(r[16:13] % 4'd9);
        mem1_mem2_mem_oper_i = mem_oper_t'(r[20:17] % 4'd9);
        mem2_wb_mem_oper_i   = mem_oper_t'(r[24:21] % 4'd9);
        // rare csr, back-pressure, trap and interrupt events
        r = xorshift32();
        id_is_csr_i         = (r[2:0] == 3'd0);
        ex_is_csr_i         = (r[5:3] == 3'd0);
        mem1_is_csr_i       = (r[8:6] == 3'd0);
        mem2_is_csr_i       = (r[11:9] == 3'd0);
        lsu_req_stall_i     = (r[14:12] == 3'd0);
        mem2_stall_needed_i = (r[17:15] == 3'd0);
        ex_new_pc_en_i      = (r[19:18] == 2'd0);
        mstatus_mie_i       = r[20];
        current_plvl_i      = r[21] ? PRIV_LVL_M : PRIV_LVL_U;
        irq_pending_i       = (r[24:22] == 3'd0) ? irqs_t'(r[27:25]) : '0;
        mem_trap_i          = (r[31:28] == 4'd0) ? trap_list[r[27:25]] : NO_TRAP;
        id_ex_rs1_data_i       = xorshift32();
        id_ex_rs2_data_i       = xorshift32();
        ex_mem1_alu_result_i   = xorshift32();
        mem1_mem2_alu_result_i = xorshift32();
        mem2_wb_alu_result_i   = xorshift32();
        mem2_wb_lsu_rdata_i    = xorshift32();
    endtask

    always @(negedge clk_i)
    begin
        #4;
        compare_outputs();
    end

    initial
    begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired, the run did not finish");
    end

    initial
    begin
        rng_state  = 32'd35343;
        model_wait = 1'b0;
        trap_list  = '{INSTR_MISALIGNED, ILLEGAL_INSTR, BREAKPOINT, LOAD_MISALIGNED,
                       STORE_MISALIGNED, ECALL_U, ECALL_M, MRET};
        rstn_i = 1'b0;
        set_idle();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        // idle cycles right after reset
        repeat (IDLE_CYCLES) @(posedge clk_i);
        for (int i = 0; i < NUM_CYCLES; i++)
        begin
            #1;
            drive_random();
            @(posedge clk_i);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule
